//--- Bender.yml
package:
  name: mem_subsys

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/lsu_pkg.sv
      - src/bus_pkg.sv
      - src/lsu_access.sv
      - src/fetch_port.sv
      - src/bus_arbiter.sv
      - src/data_ram.sv
      - src/mem_subsys_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/tb_mem_subsys.sv

//--- project.f
+incdir+src
src/lsu_pkg.sv
src/bus_pkg.sv
src/lsu_access.sv
src/fetch_port.sv
src/bus_arbiter.sv
src/data_ram.sv
src/mem_subsys_top.sv
tb/tb_mem_subsys.sv

//--- src/bus_arbiter.sv
// Round-robin arbiter joining the LSU and fetch requesters onto the single RAM port
`timescale 1ns/1ps

module bus_arbiter (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_lsu_req,
  input  bus_pkg::bus_req_t i_lsu_cmd,
  output logic              o_lsu_ack,
  output bus_pkg::bus_rsp_t o_lsu_rsp,
  input  logic              i_if_req,
  input  bus_pkg::bus_req_t i_if_cmd,
  output logic              o_if_ack,
  output bus_pkg::bus_rsp_t o_if_rsp,
  output logic              o_mem_req,
  output bus_pkg::bus_req_t o_mem_cmd,
  input  logic              i_mem_ack,
  input  bus_pkg::bus_rsp_t i_mem_rsp
);

  // Grant in progress, held until the RAM ack falls
  logic busy;
  // Granted peer, high for fetch
  logic grant_if;
  // Peer served last, high for fetch
  logic last_if;
  logic pick_if;
  logic any_req;
  logic sel_req;

  // ==============================
  // Arbitration
  // ==============================

  assign any_req = i_lsu_req | i_if_req;

  // On a tie the peer not served last wins
  always_comb begin
    if (i_lsu_req && i_if_req) begin
      pick_if = ~last_if;
    end else begin
      pick_if = i_if_req;
    end
  end

  assign sel_req = grant_if ? i_if_req : i_lsu_req;

  always_ff @(posedge i_clk) begin
    if (!i_rst) begin
      busy      <= 1'b0;
      grant_if  <= 1'b0;
      // LSU wins the first tie
      last_if   <= 1'b1;
      o_mem_req <= 1'b0;
    end else if (!busy) begin
      // RAM side must be fully idle before a new grant
      if (any_req && !o_mem_req && !i_mem_ack) begin
        busy      <= 1'b1;
        grant_if  <= pick_if;
        last_if   <= pick_if;
        o_mem_req <= 1'b1;
      end
    end else begin
      // Follow the granted peer down, never back up
      o_mem_req <= o_mem_req & sel_req;
      if (!o_mem_req && !i_mem_ack) begin
        busy <= 1'b0;
      end
    end
  end

  // Command is captured with the grant, peers hold it stable anyway
  always_ff @(posedge i_clk) begin
    if (!busy && any_req && !o_mem_req && !i_mem_ack) begin
      o_mem_cmd <= pick_if ? i_if_cmd : i_lsu_cmd;
    end
  end

  // ==============================
  // Return path
  // ==============================

  // Ack and data only reach the granted peer
  assign o_lsu_ack = busy & ~grant_if & i_mem_ack;
  assign o_if_ack  = busy & grant_if & i_mem_ack;
  assign o_lsu_rsp = grant_if ? '0 : i_mem_rsp;
  assign o_if_rsp  = grant_if ? i_mem_rsp : '0;

endmodule

//--- src/bus_pkg.sv
// Shared RAM bus types used by both peers, the arbiter and the RAM
`include "mem_macros.svh"

package bus_pkg;

  // ==============================
  // Word views
  // ==============================

  // One RAM word, seen whole or as eight byte lanes
  typedef union packed {
    logic [63:0]     dword;
    // Lane 0 is the least significant byte
    logic [7:0][7:0] bytes;
  } mem_word_u;

  // ==============================
  // Bus payloads
  // ==============================

  // Request toward the RAM
  typedef struct packed {
    // Word index, byte offset already stripped
    logic [`MEM_IDX_BITS-1:0] idx;
    // Write data, already moved to its lanes
    logic [63:0]              wdata;
    // One bit per byte lane, only honoured on writes
    logic [7:0]               mask;
    logic                     we;
  } bus_req_t;

  // Read word coming back with ack
  typedef struct packed {
    logic [63:0] rdata;
  } bus_rsp_t;

endpackage

//--- src/data_ram.sv
// Single-port RAM of 64-bit words with byte-masked writes behind a four-phase slave port
`timescale 1ns/1ps
`include "mem_macros.svh"

module data_ram (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_req,
  input  bus_pkg::bus_req_t i_cmd,
  output logic              o_ack,
  output bus_pkg::bus_rsp_t o_rsp
);

  bus_pkg::mem_word_u mem [`MEM_WORDS];
  // Write data seen by lane
  bus_pkg::mem_word_u wr_word;
  // One access per request, taken on the edge that raises ack
  logic               do_access;

  assign wr_word.dword = i_cmd.wdata;
  assign do_access     = i_req & ~o_ack;

  // ==============================
  // Slave handshake
  // ==============================

  always_ff @(posedge i_clk) begin
    if (!i_rst) begin
      o_ack <= 1'b0;
    end else if (do_access) begin
      o_ack <= 1'b1;
    end else if (!i_req && o_ack) begin
      // Release one cycle after req is seen low
      o_ack <= 1'b0;
    end
  end

  // ==============================
  // Storage
  // ==============================

  always_ff @(posedge i_clk) begin
    if (do_access) begin
      if (i_cmd.we) begin
        // Merge by lane, unmasked lanes keep their old bytes
        for (int i = 0; i < 8; i++) begin
          if (i_cmd.mask[i]) begin
            mem[i_cmd.idx].bytes[i] <= wr_word.bytes[i];
          end
        end
      end else begin
        o_rsp.rdata <= mem[i_cmd.idx].dword;
      end
    end
  end

endmodule

//--- src/fetch_port.sv
// Instruction fetch peer: reads one RAM word and returns the 32-bit half picked by the PC
`timescale 1ns/1ps
`include "mem_macros.svh"

module fetch_port (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_req,
  input  logic [31:0]       i_pc,
  output logic              o_ack,
  output logic [31:0]       o_instr,
  output logic              o_bus_req,
  output bus_pkg::bus_req_t o_bus_cmd,
  input  logic              i_bus_ack,
  input  bus_pkg::bus_rsp_t i_bus_rsp
);

  typedef enum logic [1:0] {ST_IDLE, ST_BUS, ST_DONE} state_e;

  state_e state;
  // High when the PC names the upper half of the word
  logic   upper_q;

  // ==============================
  // Handshake FSM
  // ==============================

  always_ff @(posedge i_clk) begin
    if (!i_rst) begin
      state     <= ST_IDLE;
      o_ack     <= 1'b0;
      o_bus_req <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (i_req) begin
            o_bus_req <= 1'b1;
            state     <= ST_BUS;
          end
        end
        ST_BUS: begin
          if (i_bus_ack) begin
            o_bus_req <= 1'b0;
            o_ack     <= 1'b1;
            state     <= ST_DONE;
          end
        end
        ST_DONE: begin
          // Wait for both sides to go quiet
          if (!i_req && !i_bus_ack) begin
            o_ack <= 1'b0;
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Read command, PC bits 1:0 ignored
  always_ff @(posedge i_clk) begin
    if (state == ST_IDLE && i_req) begin
      o_bus_cmd.idx   <= i_pc[`BYTE_OFS_BITS +: `MEM_IDX_BITS];
      o_bus_cmd.wdata <= '0;
      o_bus_cmd.mask  <= '0;
      o_bus_cmd.we    <= 1'b0;
      upper_q         <= i_pc[`BYTE_OFS_BITS-1];
    end
    // Instruction stays put until the next fetch completes
    if (state == ST_BUS && i_bus_ack) begin
      o_instr <= upper_q ? i_bus_rsp.rdata[63:32] : i_bus_rsp.rdata[31:0];
    end
  end

endmodule

//--- src/lsu_access.sv
// Load/store peer: turns one memory operation into a byte-masked bus access and formats loads
`timescale 1ns/1ps
`include "mem_macros.svh"

module lsu_access (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_req,
  input  lsu_pkg::lsu_cmd_t i_cmd,
  output logic              o_ack,
  output lsu_pkg::lsu_rsp_t o_rsp,
  output logic              o_bus_req,
  output bus_pkg::bus_req_t o_bus_cmd,
  input  logic              i_bus_ack,
  input  bus_pkg::bus_rsp_t i_bus_rsp
);

  typedef enum logic [1:0] {ST_IDLE, ST_BUS, ST_DONE} state_e;

  state_e                    state;
  // Size decode of the incoming command
  logic [7:0]                base_mask;
  logic [`BYTE_OFS_BITS-1:0] align;
  logic [`BYTE_OFS_BITS-1:0] ofs;
  // Store path
  bus_pkg::mem_word_u        st_src;
  bus_pkg::mem_word_u        st_lanes;
  // Load path
  bus_pkg::mem_word_u        ld_src;
  bus_pkg::mem_word_u        ld_lanes;
  bus_pkg::mem_word_u        ld_ext;
  // Captured at request time for formatting the load
  lsu_pkg::mem_op_e          op_q;
  logic [`BYTE_OFS_BITS-1:0] ofs_q;
  logic                      we_q;

  // ==============================
  // Command decode
  // ==============================

  // Base mask by size, align clears the offset bits below the size
  always_comb begin
    case (i_cmd.op)
      lsu_pkg::MEM_LB, lsu_pkg::MEM_LBU: begin
        base_mask = 8'h01;
        align     = 3'b111;
      end
      lsu_pkg::MEM_LH, lsu_pkg::MEM_LHU: begin
        base_mask = 8'h03;
        align     = 3'b110;
      end
      lsu_pkg::MEM_LW, lsu_pkg::MEM_LWU: begin
        base_mask = 8'h0f;
        align     = 3'b100;
      end
      lsu_pkg::MEM_LD: begin
        base_mask = 8'hff;
        align     = 3'b000;
      end
      default: begin
        base_mask = 8'h00;
        align     = 3'b000;
      end
    endcase
    ofs = i_cmd.addr[`BYTE_OFS_BITS-1:0] & align;
  end

  // Rotate store data up so byte 0 lands on lane ofs
  always_comb begin
    st_src.dword = i_cmd.wdata;
    for (int i = 0; i < 8; i++) begin
      st_lanes.bytes[i] = st_src.bytes[3'(i - ofs)];
    end
  end

  // ==============================
  // Load formatting
  // ==============================

  always_comb begin
    ld_src.dword = i_bus_rsp.rdata;
    // Rotate down so the addressed lane becomes byte 0
    for (int i = 0; i < 8; i++) begin
      ld_lanes.bytes[i] = ld_src.bytes[3'(i + ofs_q)];
    end
    case (op_q)
      lsu_pkg::MEM_LB:  ld_ext.dword = {{56{ld_lanes.bytes[0][7]}}, ld_lanes.bytes[0]};
      lsu_pkg::MEM_LBU: ld_ext.dword = {56'd0, ld_lanes.bytes[0]};
      lsu_pkg::MEM_LH:  ld_ext.dword = {{48{ld_lanes.bytes[1][7]}}, ld_lanes.bytes[1:0]};
      lsu_pkg::MEM_LHU: ld_ext.dword = {48'd0, ld_lanes.bytes[1:0]};
      lsu_pkg::MEM_LW:  ld_ext.dword = {{32{ld_lanes.bytes[3][7]}}, ld_lanes.bytes[3:0]};
      lsu_pkg::MEM_LWU: ld_ext.dword = {32'd0, ld_lanes.bytes[3:0]};
      // Double word, offset is always zero here
      default:          ld_ext.dword = ld_lanes.dword;
    endcase
  end

  // ==============================
  // Handshake FSM
  // ==============================

  always_ff @(posedge i_clk) begin
    if (!i_rst) begin
      state     <= ST_IDLE;
      o_ack     <= 1'b0;
      o_bus_req <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (i_req) begin
            if (i_cmd.op == lsu_pkg::MEM_NONE) begin
              // Nothing to move, ack straight away
              o_ack <= 1'b1;
              state <= ST_DONE;
            end else begin
              o_bus_req <= 1'b1;
              state     <= ST_BUS;
            end
          end
        end
        ST_BUS: begin
          if (i_bus_ack) begin
            o_bus_req <= 1'b0;
            o_ack     <= 1'b1;
            state     <= ST_DONE;
          end
        end
        ST_DONE: begin
          // Bus ack must be gone too before a new access may start
          if (!i_req && !i_bus_ack) begin
            o_ack <= 1'b0;
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Bus command and result registers
  always_ff @(posedge i_clk) begin
    if (state == ST_IDLE && i_req) begin
      op_q            <= i_cmd.op;
      ofs_q           <= ofs;
      we_q            <= i_cmd.we;
      o_bus_cmd.idx   <= i_cmd.addr[`BYTE_OFS_BITS +: `MEM_IDX_BITS];
      o_bus_cmd.wdata <= st_lanes.dword;
      o_bus_cmd.mask  <= base_mask << ofs;
      o_bus_cmd.we    <= i_cmd.we;
      // No-access ops report zero
      o_rsp.rdata     <= '0;
    end else if (state == ST_BUS && i_bus_ack) begin
      o_rsp.rdata <= we_q ? 64'd0 : ld_ext.dword;
    end
  end

endmodule

//--- src/lsu_pkg.sv
// Load/store types: operation encoding plus the command and response of the LSU port
package lsu_pkg;

  // ==============================
  // Memory operation code
  // ==============================

  // Bit 0 picks zero extension on load, bits 2:1 pick the size
  typedef enum logic [2:0] {
    MEM_LB   = 3'b000,
    MEM_LBU  = 3'b001,
    MEM_LH   = 3'b010,
    MEM_LHU  = 3'b011,
    MEM_LW   = 3'b100,
    MEM_LWU  = 3'b101,
    MEM_LD   = 3'b110,
    // No memory access at all, acked without touching the bus
    MEM_NONE = 3'b111
  } mem_op_e;

  // ==============================
  // Port payloads
  // ==============================

  // Command from the outside, 100 bits
  typedef struct packed {
    // Byte address, aligned down to the access size
    logic [31:0] addr;
    // Store data, taken from the low lanes
    logic [63:0] wdata;
    mem_op_e     op;
    // High for a store
    logic        we;
  } lsu_cmd_t;

  // Result returned alongside ack
  typedef struct packed {
    // Extended load value, zero after a store
    logic [63:0] rdata;
  } lsu_rsp_t;

endpackage

//--- src/mem_macros.svh
// Memory geometry constants, included by every file that sizes the RAM or slices an address
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// ==============================
// RAM geometry
// ==============================

// Number of 64-bit words in the data RAM
`define MEM_WORDS 256

// Word index width, log2 of MEM_WORDS
`define MEM_IDX_BITS 8

// Byte offset inside one 64-bit word
`define BYTE_OFS_BITS 3

`endif

//--- src/mem_subsys_top.sv
// Memory subsystem top: LSU and fetch peers sharing the data RAM through the arbiter
`timescale 1ns/1ps

module mem_subsys_top (
  input  logic              i_clk,
  input  logic              i_rst,
  // Load/store port
  input  logic              i_lsu_req,
  input  lsu_pkg::lsu_cmd_t i_lsu_cmd,
  output logic              o_lsu_ack,
  output lsu_pkg::lsu_rsp_t o_lsu_rsp,
  // Instruction fetch port
  input  logic              i_if_req,
  input  logic [31:0]       i_if_pc,
  output logic              o_if_ack,
  output logic [31:0]       o_if_instr
);

  // ==============================
  // Internal links
  // ==============================

  // LSU to arbiter
  logic              lsu_bus_req;
  bus_pkg::bus_req_t lsu_bus_cmd;
  logic              lsu_bus_ack;
  bus_pkg::bus_rsp_t lsu_bus_rsp;
  // Fetch to arbiter
  logic              if_bus_req;
  bus_pkg::bus_req_t if_bus_cmd;
  logic              if_bus_ack;
  bus_pkg::bus_rsp_t if_bus_rsp;
  // Arbiter to RAM
  logic              mem_req;
  bus_pkg::bus_req_t mem_cmd;
  logic              mem_ack;
  bus_pkg::bus_rsp_t mem_rsp;

  lsu_access u_lsu (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_req     (i_lsu_req),
    .i_cmd     (i_lsu_cmd),
    .o_ack     (o_lsu_ack),
    .o_rsp     (o_lsu_rsp),
    .o_bus_req (lsu_bus_req),
    .o_bus_cmd (lsu_bus_cmd),
    .i_bus_ack (lsu_bus_ack),
    .i_bus_rsp (lsu_bus_rsp)
  );

  fetch_port u_fetch (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_req     (i_if_req),
    .i_pc      (i_if_pc),
    .o_ack     (o_if_ack),
    .o_instr   (o_if_instr),
    .o_bus_req (if_bus_req),
    .o_bus_cmd (if_bus_cmd),
    .i_bus_ack (if_bus_ack),
    .i_bus_rsp (if_bus_rsp)
  );

  bus_arbiter u_arb (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_lsu_req (lsu_bus_req),
    .i_lsu_cmd (lsu_bus_cmd),
    .o_lsu_ack (lsu_bus_ack),
    .o_lsu_rsp (lsu_bus_rsp),
    .i_if_req  (if_bus_req),
    .i_if_cmd  (if_bus_cmd),
    .o_if_ack  (if_bus_ack),
    .o_if_rsp  (if_bus_rsp),
    .o_mem_req (mem_req),
    .o_mem_cmd (mem_cmd),
    .i_mem_ack (mem_ack),
    .i_mem_rsp (mem_rsp)
  );

  data_ram u_ram (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_req (mem_req),
    .i_cmd (mem_cmd),
    .o_ack (mem_ack),
    .o_rsp (mem_rsp)
  );

endmodule

//--- tb/tb_mem_subsys.sv
// Self-checking testbench for mem_subsys_top, run with tb_mem_subsys as the top module
`timescale 1ns/1ps
`include "mem_macros.svh"

module tb_mem_subsys;

  // Cycles allowed for any single ack edge
  localparam int TIMEOUT_CYC = 40;

  logic              clk;
  logic              rst;
  logic              lsu_req;
  lsu_pkg::lsu_cmd_t lsu_cmd;
  logic              lsu_ack;
  lsu_pkg::lsu_rsp_t lsu_rsp;
  logic              if_req;
  logic [31:0]       if_pc;
  logic              if_ack;
  logic [31:0]       if_instr;

  // Reference copy of the RAM
  logic [63:0] ref_mem [`MEM_WORDS];
  integer      seed;
  int          n_checks;

  mem_subsys_top i_dut (
    .i_clk      (clk),
    .i_rst      (rst),
    .i_lsu_req  (lsu_req),
    .i_lsu_cmd  (lsu_cmd),
    .o_lsu_ack  (lsu_ack),
    .o_lsu_rsp  (lsu_rsp),
    .i_if_req   (if_req),
    .i_if_pc    (if_pc),
    .o_if_ack   (if_ack),
    .o_if_instr (if_instr)
  );

  always #4 clk = ~clk;

  // ==============================
  // Helpers
  // ==============================

  task automatic abort_run(string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check(string name, logic [63:0] exp, logic [63:0] act);
    n_checks++;
    assert (act === exp) else begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      abort_run("Stopping at the first mismatch");
    end
  endtask

  function automatic logic [63:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  // Lane of the first byte, address aligned down to the access size
  function automatic int lane_ofs(logic [31:0] addr, logic [2:0] op);
    int size;
    size = 1 << op[2:1];
    return int'(addr[`BYTE_OFS_BITS-1:0]) & ~(size - 1);
  endfunction

  // Store rule: low bytes of wdata land on lanes starting at the aligned offset
  task automatic store_ref(logic [31:0] addr, logic [63:0] wdata, logic [2:0] op);
    int size;
    int ofs;
    int idx;
    size = 1 << op[2:1];
    ofs  = lane_ofs(addr, op);
    idx  = int'(addr[`BYTE_OFS_BITS +: `MEM_IDX_BITS]);
    for (int b = 0; b < size; b++) begin
      ref_mem[idx][(ofs + b) * 8 +: 8] = wdata[b * 8 +: 8];
    end
  endtask

  // Load rule: gather the lanes, then sign-extend unless bit 0 of the code is set
  function automatic logic [63:0] expected_load(logic [31:0] addr, logic [2:0] op);
    int          size;
    int          ofs;
    logic [63:0] word;
    logic [63:0] val;
    size = 1 << op[2:1];
    ofs  = lane_ofs(addr, op);
    word = ref_mem[int'(addr[`BYTE_OFS_BITS +: `MEM_IDX_BITS])];
    val  = '0;
    for (int b = 0; b < size; b++) begin
      val[b * 8 +: 8] = word[(ofs + b) * 8 +: 8];
    end
    if (size < 8 && !op[0] && val[size * 8 - 1]) begin
      for (int k = size * 8; k < 64; k++) begin
        val[k] = 1'b1;
      end
    end
    return val;
  endfunction

  // ==============================
  // Four-phase transactions
  // ==============================

  task automatic lsu_transfer(input logic [31:0] addr, input logic [63:0] wdata,
                              input logic [2:0] op, input logic we,
                              output logic [63:0] rdata);
    int cnt;
    @(posedge clk);
    lsu_cmd <= '{addr: addr, wdata: wdata, op: lsu_pkg::mem_op_e'(op), we: we};
    lsu_req <= 1'b1;
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
      if (!lsu_ack && cnt >= TIMEOUT_CYC) abort_run("LSU ack never rose");
    end while (!lsu_ack);
    // Result is valid while ack is high
    rdata = lsu_rsp.rdata;
    @(posedge clk);
    lsu_req <= 1'b0;
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
      if (lsu_ack && cnt >= TIMEOUT_CYC) abort_run("LSU ack never fell");
    end while (lsu_ack);
  endtask

  task automatic fetch_instr(input logic [31:0] pc, output logic [31:0] instr);
    int cnt;
    @(posedge clk);
    if_pc  <= pc;
    if_req <= 1'b1;
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
      if (!if_ack && cnt >= TIMEOUT_CYC) abort_run("Fetch ack never rose");
    end while (!if_ack);
    instr = if_instr;
    @(posedge clk);
    if_req <= 1'b0;
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
      if (if_ack && cnt >= TIMEOUT_CYC) abort_run("Fetch ack never fell");
    end while (if_ack);
  endtask

  // Stores and no-access ops return zero, loads return the extended lanes
  task automatic access_checked(string name, logic [31:0] addr, logic [63:0] wdata,
                                logic [2:0] op, logic we);
    logic [63:0] exp;
    logic [63:0] act;
    exp = (we || op == 3'b111) ? 64'd0 : expected_load(addr, op);
    lsu_transfer(addr, wdata, op, we, act);
    if (we && op != 3'b111) store_ref(addr, wdata, op);
    check(name, exp, act);
  endtask

  task automatic fetch_checked(string name, logic [31:0] pc);
    logic [63:0] word;
    logic [31:0] exp;
    logic [31:0] act;
    word = ref_mem[int'(pc[`BYTE_OFS_BITS +: `MEM_IDX_BITS])];
    exp  = pc[2] ? word[63:32] : word[31:0];
    fetch_instr(pc, act);
    check(name, 64'(exp), 64'(act));
  endtask

  // ==============================
  // Test sequence
  // ==============================

  initial begin
    logic [63:0] data;
    logic [2:0]  op;
    clk      = 1'b0;
    rst      = 1'b0;
    lsu_req  = 1'b0;
    lsu_cmd  = '0;
    if_req   = 1'b0;
    if_pc    = '0;
    seed     = 76;
    n_checks = 0;

    repeat (3) @(posedge clk);
    rst <= 1'b1;
    @(negedge clk);
    check("reset_acks", 64'd0, {62'd0, lsu_ack, if_ack});

    // Double round trip
    access_checked("dw_store", 32'h40, rand64(), 3'b110, 1'b1);
    access_checked("dw_load", 32'h40, 64'd0, 3'b110, 1'b0);

    // Partial stores merge into existing words, offsets 0x83 and 0x89 misaligned
    access_checked("merge_base0", 32'h80, rand64(), 3'b110, 1'b1);
    access_checked("merge_byte", 32'h81, rand64(), 3'b000, 1'b1);
    access_checked("merge_byteu", 32'h85, rand64(), 3'b001, 1'b1);
    access_checked("merge_half", 32'h83, rand64(), 3'b010, 1'b1);
    access_checked("merge_chk0", 32'h80, 64'd0, 3'b110, 1'b0);
    access_checked("merge_base1", 32'h88, rand64(), 3'b110, 1'b1);
    access_checked("merge_word", 32'h8c, rand64(), 3'b100, 1'b1);
    access_checked("merge_halfu", 32'h89, rand64(), 3'b011, 1'b1);
    access_checked("merge_chk1", 32'h88, 64'd0, 3'b110, 1'b0);
    access_checked("merge_base2", 32'h90, rand64(), 3'b110, 1'b1);
    for (int i = 0; i < 8; i++) begin
      op = 3'($unsigned($random(seed)) % 6);
      access_checked($sformatf("merge_rand%0d", i), 32'h90 + 32'(i), rand64(), op, 1'b1);
      access_checked($sformatf("merge_rchk%0d", i), 32'h90, 64'd0, 3'b110, 1'b0);
    end

    // Every load size and offset, one word with top bits set and one with them clear
    access_checked("ext_neg", 32'ha0, rand64() | 64'h8080_8080_8080_8080, 3'b110, 1'b1);
    access_checked("ext_pos", 32'ha8, rand64() & 64'h7f7f_7f7f_7f7f_7f7f, 3'b110, 1'b1);
    for (int w = 0; w < 2; w++) begin
      for (int c = 0; c < 7; c++) begin
        for (int b = 0; b < 8; b++) begin
          access_checked($sformatf("ext_w%0d_op%0d_b%0d", w, c, b),
                         32'ha0 + 32'(w * 8 + b), 64'd0, 3'(c), 1'b0);
        end
      end
    end

    // Fetch both halves, low pc bits set to show they are ignored
    for (int i = 0; i < 8; i++) begin
      access_checked($sformatf("code_fill%0d", i), 32'h100 + 32'(i * 8), rand64(),
                     3'b110, 1'b1);
    end
    for (int i = 0; i < 8; i++) begin
      fetch_checked($sformatf("fetch_lo%0d", i), 32'h100 + 32'(i * 8) + 32'(i % 4));
      fetch_checked($sformatf("fetch_hi%0d", i), 32'h104 + 32'(i * 8) + 32'(i % 4));
    end

    // Contention, both peers raise req on the same edge
    for (int i = 0; i < 6; i++) begin
      data = rand64();
      fork
        access_checked($sformatf("race_st%0d", i), 32'h200 + 32'(i * 8), data,
                       3'b110, 1'b1);
        fetch_checked($sformatf("race_if_lo%0d", i), 32'h100 + 32'(i * 8));
      join
      fork
        access_checked($sformatf("race_ld%0d", i), 32'h200 + 32'(i * 9), 64'd0,
                       3'(i), 1'b0);
        fetch_checked($sformatf("race_if_hi%0d", i), 32'h104 + 32'(i * 8));
      join
    end

    // No-access op with the write flag set leaves memory alone
    access_checked("nop_store", 32'h40, rand64(), 3'b111, 1'b1);
    access_checked("nop_after", 32'h40, 64'd0, 3'b110, 1'b0);

    $display("%0d checks run", n_checks);
    $display("All checks passed");
    $finish;
  end

endmodule
